/* Makefile */
VERILATOR  = verilator
VFLAGS     = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing
TOP        = core_tb
FILELIST   = filelist.f
OBJ_DIR    = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "TESTBENCH PASSED"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* dv/core_props.sv */
module core_props (
	input logic clk,
	input logic rst,
	input logic do_system,
	input logic wb_valid,
	input logic alu_overflow
);
	timeunit 1ns;
	timeprecision 1ps;

	// checked from the first reset edge up to the edge after release
	reset_quiet: assert property (@(posedge clk) rst |=> (!wb_valid && !alu_overflow))
		else $error("wb_valid or alu_overflow high during or right after reset");

	ovf_needs_valid: assert property (@(posedge clk) disable iff (rst)
		alu_overflow |-> wb_valid)
		else $error("alu_overflow high without wb_valid");

	// a frozen edge never produces a write-back pulse
	frozen_no_pulse: assert property (@(posedge clk) disable iff (rst)
		!do_system |=> !wb_valid)
		else $error("wb_valid high after an edge with do_system low");

endmodule

bind core_top core_props u_core_props (
	.clk          (clk),
	.rst          (rst),
	.do_system    (do_system),
	.wb_valid     (wb_valid),
	.alu_overflow (alu_overflow)
);

/* dv/core_tb.sv */
module core_tb import core_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int num_instr     = 2000;
	localparam int clk_period_ns = 40;
	localparam int drain_limit   = 40;
	localparam int watchdog_ns   = num_instr * 2 * clk_period_ns + 100 * clk_period_ns;
	localparam int unsigned rand_seed = 32'h5480ba96;
	localparam longint s32_max   = 64'sd2147483647;
	localparam longint s32_min   = -64'sd2147483648;

	typedef struct {
		reg_addr_t rd;
		word_t     data;
		bit        ovf;
		alu_op_e   op;
	} wb_exp_t;

	logic      clk = 1'b0;
	logic      rst = 1'b1;
	logic      do_system = 1'b0;
	word_t     instruction = '0;
	logic      wb_valid;
	reg_addr_t wb_addr;
	word_t     wb_data;
	logic      alu_overflow;

	word_t   model_regs [32];
	wb_exp_t exp_q [$];
	int      accepted;
	int      drain_cycles;

	sub_op_e defined_subs [10] = '{sub_add, sub_sub, sub_and, sub_xor, sub_or,
		sub_nor, sub_slt, sub_sll, sub_srl, sub_sra};

	core_top u_core_top (
		.clk          (clk),
		.rst          (rst),
		.instruction  (instruction),
		.do_system    (do_system),
		.wb_valid     (wb_valid),
		.wb_addr      (wb_addr),
		.wb_data      (wb_data),
		.alu_overflow (alu_overflow)
	);

	always #(clk_period_ns / 2) clk = ~clk;

	task automatic report_failure(input string reason);
		$display("%s", reason);
		$display("TESTBENCH FAILED");
		$fatal(1, "%s", reason);
	endtask

	task automatic compare_addr(input reg_addr_t expected, input reg_addr_t actual);
		if (actual !== expected) begin
			$display("ERROR wb_addr expected 0x%h actual 0x%h", expected, actual);
			report_failure("write-back address mismatch");
		end
	endtask

	task automatic compare_data(input word_t expected, input word_t actual);
		if (actual !== expected) begin
			$display("ERROR wb_data expected 0x%h actual 0x%h", expected, actual);
			report_failure("write-back data mismatch");
		end
	endtask

	task automatic compare_ovf(input alu_op_e op, input bit expected, input bit actual);
		if (actual !== expected) begin
			$display("ERROR alu_overflow expected 0x%h actual 0x%h op %s",
				expected, actual, op.name());
			report_failure("overflow flag mismatch");
		end
	endtask

	function automatic bit sub_is_defined(input logic [4:0] code);
		case (code)
			sub_add, sub_sub, sub_and, sub_xor, sub_or,
			sub_nor, sub_slt, sub_sll, sub_srl, sub_sra: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	function automatic bit opcode_is_defined(input logic [5:0] code);
		case (code)
			op_alu_reg, op_addi, op_ori, op_xori, op_movi: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	function automatic bit signed_overflow(input longint wide);
		return (wide > s32_max) || (wide < s32_min);
	endfunction

	// small register pool so dependencies are frequent
	function automatic reg_addr_t pool_reg();
		return reg_addr_t'($urandom_range(0, 7));
	endfunction

	function automatic word_t random_instruction();
		word_t       instr;
		int unsigned pick;
		logic [5:0]  opcode;
		logic [4:0]  sub;
		instr = $urandom;
		pick = $urandom_range(0, 99);
		sub = '0;
		if (pick < 45) begin
			opcode = op_alu_reg;
			sub = defined_subs[$urandom_range(0, 9)];
		end else if (pick < 56) begin
			opcode = op_addi;
		end else if (pick < 64) begin
			opcode = op_ori;
		end else if (pick < 72) begin
			opcode = op_xori;
		end else if (pick < 84) begin
			opcode = op_movi;
		end else if (pick < 92) begin
			opcode = op_alu_reg;
			do
				sub = 5'($urandom);
			while (sub_is_defined(sub));
		end else begin
			do
				opcode = 6'($urandom);
			while (opcode_is_defined(opcode));
		end
		instr[30:25] = opcode;
		instr[24:20] = pool_reg();
		// movi keeps all twenty immediate bits random
		if (opcode != op_movi)
			instr[19:15] = pool_reg();
		if (opcode == op_alu_reg) begin
			instr[14:10] = pool_reg();
			instr[4:0]   = sub;
		end
		return instr;
	endfunction

	// architectural model that takes one instruction in program order
	task automatic model_accept(input word_t instr);
		logic [5:0]         opcode;
		logic [4:0]         sub;
		reg_addr_t          rt;
		logic signed [14:0] imm15;
		logic signed [19:0] imm20;
		word_t              a;
		word_t              b;
		word_t              value;
		longint             a_s;
		longint             b_s;
		longint             wide;
		bit                 writes;
		bit                 ovf;
		alu_op_e            kind;
		wb_exp_t            entry;
		opcode = instr[30:25];
		sub    = instr[4:0];
		rt     = instr[24:20];
		imm15  = instr[14:0];
		imm20  = instr[19:0];
		a      = model_regs[instr[19:15]];
		b      = model_regs[instr[14:10]];
		a_s    = longint'($signed(a));
		b_s    = longint'($signed(b));
		value  = '0;
		writes = 1'b1;
		ovf    = 1'b0;
		kind   = alu_add;
		case (opcode)
			op_alu_reg: begin
				case (sub)
					sub_add: begin
						wide  = a_s + b_s;
						value = word_t'(wide);
						ovf   = signed_overflow(wide);
					end
					sub_sub: begin
						kind  = alu_sub;
						wide  = a_s - b_s;
						value = word_t'(wide);
						ovf   = signed_overflow(wide);
					end
					sub_and: begin
						kind  = alu_and;
						value = a & b;
					end
					sub_or: begin
						kind  = alu_or;
						value = a | b;
					end
					sub_xor: begin
						kind  = alu_xor;
						value = a ^ b;
					end
					sub_nor: begin
						kind  = alu_nor;
						value = ~(a | b);
					end
					sub_slt: begin
						kind  = alu_slt;
						value = (a_s < b_s) ? 32'd1 : 32'd0;
					end
					sub_sll: begin
						kind  = alu_sll;
						value = a << b[4:0];
					end
					sub_srl: begin
						kind  = alu_srl;
						value = a >> b[4:0];
					end
					sub_sra: begin
						kind  = alu_sra;
						value = word_t'(a_s >>> b[4:0]);
					end
					default: writes = 1'b0;
				endcase
			end
			op_addi: begin
				wide  = a_s + longint'(imm15);
				value = word_t'(wide);
				ovf   = signed_overflow(wide);
			end
			op_ori: begin
				kind  = alu_or;
				value = a | {17'd0, instr[14:0]};
			end
			op_xori: begin
				kind  = alu_xor;
				value = a ^ {17'd0, instr[14:0]};
			end
			op_movi: begin
				kind  = alu_pass_b;
				value = word_t'(longint'(imm20));
			end
			default: writes = 1'b0;
		endcase
		if (writes) begin
			model_regs[rt] = value;
			entry.rd   = rt;
			entry.data = value;
			entry.ovf  = ovf;
			entry.op   = kind;
			exp_q.push_back(entry);
		end
	endtask

	task automatic check_writeback();
		wb_exp_t expected;
		if (exp_q.size() == 0) begin
			report_failure("write-back pulse with no instruction pending in the model");
		end else begin
			expected = exp_q.pop_front();
			compare_addr(expected.rd, wb_addr);
			compare_data(expected.data, wb_data);
			compare_ovf(expected.op, expected.ovf, alu_overflow);
		end
	endtask

	// outputs settle after the rising edge
	always @(negedge clk) begin
		if (!rst && wb_valid === 1'b1)
			check_writeback();
	end

	initial begin
		#(watchdog_ns);
		report_failure("watchdog expired before the instruction stream finished");
	end

	initial begin
		void'($urandom(rand_seed));
		for (int i = 0; i < 32; i++)
			model_regs[i] = '0;
		accepted = 0;
		repeat (5) @(posedge clk);
		rst <= 1'b0;
		while (accepted < num_instr) begin
			@(posedge clk);
			if (!rst && do_system) begin
				model_accept(instruction);
				accepted++;
			end
			if (accepted < num_instr) begin
				instruction <= random_instruction();
				do_system   <= ($urandom_range(0, 99) < 80);
			end
		end
		// opcode zero is a nop
		instruction <= '0;
		do_system   <= 1'b1;
		drain_cycles = 0;
		while (exp_q.size() != 0 && drain_cycles < drain_limit) begin
			@(posedge clk);
			drain_cycles++;
		end
		repeat (4) @(posedge clk);
		if (exp_q.size() == 0) begin
			$display("TESTBENCH PASSED");
			$finish;
		end else begin
			report_failure("pipeline drained with write-backs still missing");
		end
	end

endmodule

/* filelist.f */
source/core_pkg.sv
source/core_regfile.sv
source/core_decode.sv
source/core_execute.sv
source/core_result.sv
source/core_top.sv
dv/core_props.sv
dv/core_tb.sv

/* source/core_decode.sv */
module core_decode import core_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  logic      do_system,
	input  word_t     instruction,
	input  word_t     ra_data,
	input  word_t     rb_data,
	input  logic      fw_ex_valid,
	input  reg_addr_t fw_ex_rd,
	input  word_t     fw_ex_data,
	input  logic      fw_rs_valid,
	input  reg_addr_t fw_rs_rd,
	input  word_t     fw_rs_data,
	output reg_addr_t ra_addr,
	output reg_addr_t rb_addr,
	output logic      ex_valid,
	output alu_op_e   ex_op,
	output word_t     ex_src1,
	output word_t     ex_src2,
	output reg_addr_t ex_rd,
	output logic      ex_ovf_check
);

	word_t     instr_q;
	word_t     opnd_a;
	word_t     opnd_b;
	word_t     sext15;
	word_t     zext15;
	word_t     sext20;
	logic      dec_valid;
	alu_op_e   dec_op;
	word_t     dec_src2;
	logic      dec_ovf;
	reg_addr_t dec_rd;

	// youngest producer wins: execute, then result, then regfile
	function automatic word_t fwd_operand(input reg_addr_t addr, input word_t rf_data);
		word_t value;
		value = rf_data;
		if (fw_rs_valid && fw_rs_rd == addr)
			value = fw_rs_data;
		if (fw_ex_valid && fw_ex_rd == addr)
			value = fw_ex_data;
		return value;
	endfunction

	always_ff @(posedge clk) begin
		if (rst)
			instr_q <= '0;
		else if (do_system)
			instr_q <= instruction;
	end

	assign ra_addr = instr_q[ra_msb:ra_lsb];
	assign rb_addr = instr_q[rb_msb:rb_lsb];
	assign dec_rd  = instr_q[rt_msb:rt_lsb];

	assign sext15 = {{17{instr_q[imm15_msb]}}, instr_q[imm15_msb:imm_lsb]};
	assign zext15 = {17'd0, instr_q[imm15_msb:imm_lsb]};
	assign sext20 = {{12{instr_q[imm20_msb]}}, instr_q[imm20_msb:imm_lsb]};

	assign opnd_a = fwd_operand(ra_addr, ra_data);
	assign opnd_b = fwd_operand(rb_addr, rb_data);

	always_comb begin
		dec_valid = 1'b0;
		dec_op    = alu_add;
		dec_src2  = opnd_b;
		dec_ovf   = 1'b0;
		case (instr_q[op_msb:op_lsb])
			op_alu_reg: begin
				dec_valid = 1'b1;
				case (instr_q[sub_msb:sub_lsb])
					sub_add: begin
						dec_op  = alu_add;
						dec_ovf = 1'b1;
					end
					sub_sub: begin
						dec_op  = alu_sub;
						dec_ovf = 1'b1;
					end
					sub_and: dec_op = alu_and;
					sub_or:  dec_op = alu_or;
					sub_xor: dec_op = alu_xor;
					sub_nor: dec_op = alu_nor;
					sub_slt: dec_op = alu_slt;
					sub_sll: dec_op = alu_sll;
					sub_srl: dec_op = alu_srl;
					sub_sra: dec_op = alu_sra;
					default: dec_valid = 1'b0;
				endcase
			end
			op_addi: begin
				dec_valid = 1'b1;
				dec_op    = alu_add;
				dec_src2  = sext15;
				dec_ovf   = 1'b1;
			end
			op_ori: begin
				dec_valid = 1'b1;
				dec_op    = alu_or;
				dec_src2  = zext15;
			end
			op_xori: begin
				dec_valid = 1'b1;
				dec_op    = alu_xor;
				dec_src2  = zext15;
			end
			op_movi: begin
				dec_valid = 1'b1;
				dec_op    = alu_pass_b;
				dec_src2  = sext20;
			end
			default: dec_valid = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			ex_valid     <= 1'b0;
			ex_op        <= alu_add;
			ex_src1      <= '0;
			ex_src2      <= '0;
			ex_rd        <= '0;
			ex_ovf_check <= 1'b0;
		end else if (do_system) begin
			ex_valid     <= dec_valid;
			ex_op        <= dec_op;
			ex_src1      <= opnd_a;
			ex_src2      <= dec_src2;
			ex_rd        <= dec_rd;
			ex_ovf_check <= dec_ovf;
		end
	end

endmodule

/* source/core_execute.sv */
module core_execute import core_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  logic      do_system,
	input  logic      ex_valid,
	input  alu_op_e   ex_op,
	input  word_t     ex_src1,
	input  word_t     ex_src2,
	input  reg_addr_t ex_rd,
	input  logic      ex_ovf_check,
	output logic      fw_ex_valid,
	output reg_addr_t fw_ex_rd,
	output word_t     fw_ex_data,
	output logic      rs_valid,
	output reg_addr_t rs_rd,
	output word_t     rs_data,
	output logic      rs_ovf
);

	word_t sum;
	word_t diff;
	word_t alu_result;
	logic  add_ovf;
	logic  sub_ovf;
	logic  ovf;

	assign sum  = ex_src1 + ex_src2;
	assign diff = ex_src1 - ex_src2;

	// signed overflow: sign of result disagrees with operand signs
	assign add_ovf = (ex_src1[31] == ex_src2[31]) && (sum[31] != ex_src1[31]);
	assign sub_ovf = (ex_src1[31] != ex_src2[31]) && (diff[31] != ex_src1[31]);

	always_comb begin
		alu_result = '0;
		ovf        = 1'b0;
		case (ex_op)
			alu_add: begin
				alu_result = sum;
				ovf        = add_ovf;
			end
			alu_sub: begin
				alu_result = diff;
				ovf        = sub_ovf;
			end
			alu_and:    alu_result = ex_src1 & ex_src2;
			alu_or:     alu_result = ex_src1 | ex_src2;
			alu_xor:    alu_result = ex_src1 ^ ex_src2;
			alu_nor:    alu_result = ~(ex_src1 | ex_src2);
			alu_slt:    alu_result = {31'd0, $signed(ex_src1) < $signed(ex_src2)};
			// shift amount is the low five bits of the second operand
			alu_sll:    alu_result = ex_src1 << ex_src2[4:0];
			alu_srl:    alu_result = ex_src1 >> ex_src2[4:0];
			alu_sra:    alu_result = word_t'($signed(ex_src1) >>> ex_src2[4:0]);
			alu_pass_b: alu_result = ex_src2;
			default:    alu_result = '0;
		endcase
	end

	assign fw_ex_valid = ex_valid;
	assign fw_ex_rd    = ex_rd;
	assign fw_ex_data  = alu_result;

	always_ff @(posedge clk) begin
		if (rst) begin
			rs_valid <= 1'b0;
			rs_rd    <= '0;
			rs_data  <= '0;
			rs_ovf   <= 1'b0;
		end else if (do_system) begin
			rs_valid <= ex_valid;
			rs_rd    <= ex_rd;
			rs_data  <= alu_result;
			rs_ovf   <= ex_valid && ex_ovf_check && ovf;
		end
	end

endmodule

/* source/core_pkg.sv */
package core_pkg;

	typedef logic [4:0]  reg_addr_t;
	typedef logic [31:0] word_t;

	// major opcodes, bits 30:25
	typedef enum logic [5:0] {
		op_alu_reg = 6'b100000,
		op_movi    = 6'b100010,
		op_addi    = 6'b101000,
		op_xori    = 6'b101011,
		op_ori     = 6'b101100
	} opcode_e;

	// sub-operations of op_alu_reg, bits 4:0
	typedef enum logic [4:0] {
		sub_add = 5'b00000,
		sub_sub = 5'b00001,
		sub_and = 5'b00010,
		sub_xor = 5'b00011,
		sub_or  = 5'b00100,
		sub_nor = 5'b00101,
		sub_slt = 5'b00110,
		sub_sll = 5'b01100,
		sub_srl = 5'b01101,
		sub_sra = 5'b01110
	} sub_op_e;

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_nor,
		alu_slt,
		alu_sll,
		alu_srl,
		alu_sra,
		alu_pass_b
	} alu_op_e;

	// instruction field positions
	localparam int op_msb    = 30;
	localparam int op_lsb    = 25;
	localparam int rt_msb    = 24;
	localparam int rt_lsb    = 20;
	localparam int ra_msb    = 19;
	localparam int ra_lsb    = 15;
	localparam int rb_msb    = 14;
	localparam int rb_lsb    = 10;
	localparam int sub_msb   = 4;
	localparam int sub_lsb   = 0;
	localparam int imm15_msb = 14;
	localparam int imm20_msb = 19;
	localparam int imm_lsb   = 0;

endpackage

/* source/core_regfile.sv */
module core_regfile import core_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  reg_addr_t ra_addr,
	input  reg_addr_t rb_addr,
	input  logic      wr_en,
	input  reg_addr_t wr_addr,
	input  word_t     wr_data,
	output word_t     ra_data,
	output word_t     rb_data
);

	word_t regs [32];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (wr_en) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// write-through, a same-cycle write is seen by the readers
	always_comb begin
		if (wr_en && wr_addr == ra_addr)
			ra_data = wr_data;
		else
			ra_data = regs[ra_addr];
	end

	always_comb begin
		if (wr_en && wr_addr == rb_addr)
			rb_data = wr_data;
		else
			rb_data = regs[rb_addr];
	end

endmodule

/* source/core_result.sv */
module core_result import core_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  logic      do_system,
	input  logic      rs_valid,
	input  reg_addr_t rs_rd,
	input  word_t     rs_data,
	input  logic      rs_ovf,
	output logic      wr_en,
	output reg_addr_t wr_addr,
	output word_t     wr_data,
	output logic      wb_valid,
	output reg_addr_t wb_addr,
	output word_t     wb_data,
	output logic      alu_overflow
);

	// regfile is written on the same enabled edge that loads the result register
	assign wr_en   = rs_valid && do_system;
	assign wr_addr = rs_rd;
	assign wr_data = rs_data;

	always_ff @(posedge clk) begin
		if (rst) begin
			wb_valid     <= 1'b0;
			wb_addr      <= '0;
			wb_data      <= '0;
			alu_overflow <= 1'b0;
		end else if (do_system) begin
			wb_valid     <= rs_valid;
			alu_overflow <= rs_valid && rs_ovf;
			if (rs_valid) begin
				wb_addr <= rs_rd;
				wb_data <= rs_data;
			end
		end else begin
			// frozen cycle, no pulse
			wb_valid     <= 1'b0;
			alu_overflow <= 1'b0;
		end
	end

endmodule

/* source/core_top.sv */
module core_top import core_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  word_t     instruction,
	input  logic      do_system,
	output logic      wb_valid,
	output reg_addr_t wb_addr,
	output word_t     wb_data,
	output logic      alu_overflow
);

	// regfile
	reg_addr_t ra_addr;
	reg_addr_t rb_addr;
	word_t     ra_data;
	word_t     rb_data;
	logic      wr_en;
	reg_addr_t wr_addr;
	word_t     wr_data;

	// decode to execute
	logic      ex_valid;
	alu_op_e   ex_op;
	word_t     ex_src1;
	word_t     ex_src2;
	reg_addr_t ex_rd;
	logic      ex_ovf_check;

	// execute forwarding and result link
	logic      fw_ex_valid;
	reg_addr_t fw_ex_rd;
	word_t     fw_ex_data;
	logic      rs_valid;
	reg_addr_t rs_rd;
	word_t     rs_data;
	logic      rs_ovf;

	core_decode u_decode (
		.clk          (clk),
		.rst          (rst),
		.do_system    (do_system),
		.instruction  (instruction),
		.ra_data      (ra_data),
		.rb_data      (rb_data),
		.fw_ex_valid  (fw_ex_valid),
		.fw_ex_rd     (fw_ex_rd),
		.fw_ex_data   (fw_ex_data),
		.fw_rs_valid  (wr_en),
		.fw_rs_rd     (wr_addr),
		.fw_rs_data   (wr_data),
		.ra_addr      (ra_addr),
		.rb_addr      (rb_addr),
		.ex_valid     (ex_valid),
		.ex_op        (ex_op),
		.ex_src1      (ex_src1),
		.ex_src2      (ex_src2),
		.ex_rd        (ex_rd),
		.ex_ovf_check (ex_ovf_check)
	);

	core_regfile u_regfile (
		.clk     (clk),
		.rst     (rst),
		.ra_addr (ra_addr),
		.rb_addr (rb_addr),
		.wr_en   (wr_en),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.ra_data (ra_data),
		.rb_data (rb_data)
	);

	core_execute u_execute (
		.clk          (clk),
		.rst          (rst),
		.do_system    (do_system),
		.ex_valid     (ex_valid),
		.ex_op        (ex_op),
		.ex_src1      (ex_src1),
		.ex_src2      (ex_src2),
		.ex_rd        (ex_rd),
		.ex_ovf_check (ex_ovf_check),
		.fw_ex_valid  (fw_ex_valid),
		.fw_ex_rd     (fw_ex_rd),
		.fw_ex_data   (fw_ex_data),
		.rs_valid     (rs_valid),
		.rs_rd        (rs_rd),
		.rs_data      (rs_data),
		.rs_ovf       (rs_ovf)
	);

	core_result u_result (
		.clk          (clk),
		.rst          (rst),
		.do_system    (do_system),
		.rs_valid     (rs_valid),
		.rs_rd        (rs_rd),
		.rs_data      (rs_data),
		.rs_ovf       (rs_ovf),
		.wr_en        (wr_en),
		.wr_addr      (wr_addr),
		.wr_data      (wr_data),
		.wb_valid     (wb_valid),
		.wb_addr      (wb_addr),
		.wb_data      (wb_data),
		.alu_overflow (alu_overflow)
	);

endmodule
